//--- logic/pic_pkg.sv
// Shared definitions for the interrupt controller command and acknowledge logic
// Level widths, the decoded views of the command byte, OCW2 operation codes
// and level encoding helpers

package pic_pkg;

    localparam int num_levels = 8;
    localparam int level_index_width = 3;

    typedef logic [num_levels-1:0] level_mask_t;
    typedef logic [level_index_width-1:0] level_index_t;

    typedef enum logic [2:0] {
        rotate_auto_clear  = 3'b000,
        eoi_nonspecific    = 3'b001,
        no_operation       = 3'b010,
        eoi_specific       = 3'b011,
        rotate_auto_set    = 3'b100,
        rotate_nonspecific = 3'b101,
        set_priority       = 3'b110,
        rotate_specific    = 3'b111
    } ocw2_op_t;

    // Vector base high bits are only meaningful in MCS-80 mode
    typedef struct packed {
        logic [2:0] vector_high;
        logic       marker;
        logic       level_trigger;
        logic       address_interval;
        logic       single;
        logic       ic4;
    } icw1_t;

    typedef struct packed {
        logic [2:0] reserved;
        logic       sfnm;
        logic       buffered;
        logic       master_slave;
        logic       aeoi;
        logic       upm;
    } icw4_t;

    typedef struct packed {
        ocw2_op_t     op;
        logic [1:0]   reserved;
        level_index_t level;
    } ocw2_t;

    typedef union packed {
        logic [7:0] raw;
        icw1_t      icw1;
        icw4_t      icw4;
        ocw2_t      ocw2;
    } command_word_u;

    function automatic level_mask_t to_one_hot(level_index_t index);
        return level_mask_t'(1) << index;
    endfunction

    // Lowest set bit wins, empty mask gives the top level
    function automatic level_index_t to_index(level_mask_t mask);
        level_index_t index;
        index = level_index_t'(num_levels - 1);
        for (int i = num_levels - 1; i >= 0; i--) begin
            if (mask[i]) begin
                index = level_index_t'(i);
            end
        end
        return index;
    endfunction

endpackage

//--- logic/pic_command_sequencer.sv
// Command word sequencer
// Steps through ICW1, ICW2 and the optional ICW4, then qualifies OCW writes

`timescale 1ns/1ps

module pic_command_sequencer (
    input  logic clock,
    input  logic reset,
    input  logic write_icw1,
    input  logic write_icw2_4,
    input  logic write_ocw1,
    input  logic write_ocw2,
    input  logic icw4_enabled,
    output logic load_icw2,
    output logic load_icw4,
    output logic load_ocw1,
    output logic load_ocw2
);

    typedef enum logic [1:0] {
        cmd_ready,
        cmd_expect_icw2,
        cmd_expect_icw4
    } command_state_t;

    command_state_t state;
    command_state_t next_state;

    always_comb begin
        next_state = state;
        if (write_icw1) begin
            next_state = cmd_expect_icw2;
        end else if (write_icw2_4) begin
            case (state)
                cmd_expect_icw2: next_state = icw4_enabled ? cmd_expect_icw4 : cmd_ready;
                cmd_expect_icw4: next_state = cmd_ready;
                default:         next_state = state;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= cmd_ready;
        end else begin
            state <= next_state;
        end
    end

    assign load_icw2 = write_icw2_4 && (state == cmd_expect_icw2);
    assign load_icw4 = write_icw2_4 && (state == cmd_expect_icw4);
    assign load_ocw1 = write_ocw1 && (state == cmd_ready);
    assign load_ocw2 = write_ocw2 && (state == cmd_ready);

    assert property (@(posedge clock) disable iff (reset)
        $onehot0({load_icw2, load_icw4, load_ocw1, load_ocw2}));

endmodule

//--- logic/pic_config_regs.sv
// Configuration registers
// Holds the ICW1 trigger and ICW4 request bits, the ICW2 vector base,
// the ICW4 automatic EOI bit and the OCW1 interrupt mask

`timescale 1ns/1ps

module pic_config_regs (
    input  logic                  clock,
    input  logic                  reset,
    input  pic_pkg::command_word_u data_bus,
    input  logic                  write_icw1,
    input  logic                  load_icw2,
    input  logic                  load_icw4,
    input  logic                  load_ocw1,
    output logic [4:0]            vector_base,
    output logic                  level_triggered,
    output logic                  icw4_enabled,
    output logic                  auto_eoi,
    output pic_pkg::level_mask_t  interrupt_mask
);

    import pic_pkg::*;

    // ICW1 fields
    always_ff @(posedge clock) begin
        if (reset) begin
            level_triggered <= 1'b0;
            icw4_enabled    <= 1'b0;
        end else if (write_icw1) begin
            level_triggered <= data_bus.icw1.level_trigger;
            icw4_enabled    <= data_bus.icw1.ic4;
        end
    end

    // T7-T3 of the 8086 vector
    always_ff @(posedge clock) begin
        if (reset) begin
            vector_base <= 5'b00000;
        end else if (load_icw2) begin
            vector_base <= data_bus.raw[7:3];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            auto_eoi <= 1'b0;
        end else if (load_icw4) begin
            auto_eoi <= data_bus.icw4.aeoi;
        end
    end

    // All levels masked until software says otherwise
    always_ff @(posedge clock) begin
        if (reset) begin
            interrupt_mask <= '1;
        end else if (load_ocw1) begin
            interrupt_mask <= level_mask_t'(data_bus.raw);
        end
    end

endmodule

//--- logic/pic_ack_sequencer.sv
// Interrupt acknowledge sequencer
// Raises INT on a pending request, tracks the two INTA pulses and drives
// the 8086 vector onto the data bus during the second pulse

`timescale 1ns/1ps

module pic_ack_sequencer (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 interrupt_acknowledge_n,
    input  logic                 load_ocw2,
    input  pic_pkg::level_mask_t interrupt,
    input  logic [4:0]           vector_base,
    input  pic_pkg::level_mask_t acknowledged_level,
    output logic                 latch_in_service,
    output logic                 end_of_ack_sequence,
    output logic                 interrupt_to_cpu,
    output logic                 freeze,
    output logic                 data_out_enable,
    output logic [7:0]           data_out
);

    import pic_pkg::*;

    typedef enum logic [1:0] {
        ctl_ready,
        ctl_wait_ack,
        ctl_ack1,
        ctl_ack2
    } control_state_t;

    control_state_t state;
    control_state_t next_state;
    logic           ack_n_q;
    logic           ack_fall;
    logic           ack_rise;

    always_ff @(posedge clock) begin
        if (reset) begin
            ack_n_q <= 1'b1;
        end else begin
            ack_n_q <= interrupt_acknowledge_n;
        end
    end

    assign ack_fall = ack_n_q && !interrupt_acknowledge_n;
    assign ack_rise = !ack_n_q && interrupt_acknowledge_n;

    always_comb begin
        next_state = state;
        case (state)
            // An OCW2 write holds off INT for a cycle
            ctl_ready:    if (interrupt != '0 && !load_ocw2) next_state = ctl_wait_ack;
            ctl_wait_ack: if (ack_fall) next_state = ctl_ack1;
            ctl_ack1:     if (ack_rise) next_state = ctl_ack2;
            ctl_ack2:     if (ack_rise) next_state = ctl_ready;
            default:      next_state = ctl_ready;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state            <= ctl_ready;
            interrupt_to_cpu <= 1'b0;
            freeze           <= 1'b1;
        end else begin
            state            <= next_state;
            interrupt_to_cpu <= (next_state != ctl_ready);
            freeze           <= (next_state == ctl_ack1) || (next_state == ctl_ack2);
        end
    end

    assign latch_in_service    = (state == ctl_wait_ack) && (next_state != ctl_wait_ack);
    assign end_of_ack_sequence = (state != ctl_ready) && (next_state == ctl_ready);

    // Vector goes out on the second pulse only
    assign data_out_enable = (state == ctl_ack2) && !interrupt_acknowledge_n;
    assign data_out = data_out_enable ? {vector_base, to_index(acknowledged_level)} : 8'h00;

    assert property (@(posedge clock) disable iff (reset)
        $onehot0(interrupt));

endmodule

//--- logic/pic_priority_control.sv
// Priority and end-of-interrupt control
// Keeps the acknowledged level, decodes OCW2 into EOI and rotation actions,
// and strobes request clears toward the request register

`timescale 1ns/1ps

module pic_priority_control (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  write_icw1,
    input  logic                  load_ocw2,
    input  logic                  latch_in_service,
    input  logic                  end_of_ack_sequence,
    input  logic                  auto_eoi,
    input  pic_pkg::command_word_u data_bus,
    input  pic_pkg::level_mask_t  interrupt,
    input  pic_pkg::level_mask_t  highest_level_in_service,
    output pic_pkg::level_mask_t  acknowledged_level,
    output pic_pkg::level_mask_t  end_of_interrupt,
    output pic_pkg::level_mask_t  clear_interrupt_request,
    output pic_pkg::level_index_t priority_rotate
);

    import pic_pkg::*;

    logic auto_rotate;

    always_ff @(posedge clock) begin
        if (reset) begin
            acknowledged_level <= '0;
        end else if (end_of_ack_sequence) begin
            acknowledged_level <= '0;
        end else if (latch_in_service) begin
            acknowledged_level <= interrupt;
        end
    end

    always_comb begin
        end_of_interrupt = '0;
        if (auto_eoi && end_of_ack_sequence) begin
            end_of_interrupt = acknowledged_level;
        end else if (load_ocw2) begin
            case (data_bus.ocw2.op)
                eoi_nonspecific, rotate_nonspecific: end_of_interrupt = highest_level_in_service;
                eoi_specific, rotate_specific:       end_of_interrupt = to_one_hot(data_bus.ocw2.level);
                default:                             end_of_interrupt = '0;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            auto_rotate <= 1'b0;
        end else if (load_ocw2 && data_bus.ocw2.op == rotate_auto_clear) begin
            auto_rotate <= 1'b0;
        end else if (load_ocw2 && data_bus.ocw2.op == rotate_auto_set) begin
            auto_rotate <= 1'b1;
        end
    end

    // Lowest priority level, so level 0 starts out highest
    always_ff @(posedge clock) begin
        if (reset) begin
            priority_rotate <= '1;
        end else if (auto_rotate && end_of_ack_sequence) begin
            priority_rotate <= to_index(acknowledged_level);
        end else if (load_ocw2) begin
            case (data_bus.ocw2.op)
                rotate_nonspecific:          priority_rotate <= to_index(highest_level_in_service);
                set_priority, rotate_specific: priority_rotate <= data_bus.ocw2.level;
                default:                     priority_rotate <= priority_rotate;
            endcase
        end
    end

    always_comb begin
        if (write_icw1) begin
            clear_interrupt_request = '1;
        end else if (latch_in_service) begin
            clear_interrupt_request = interrupt;
        end else begin
            clear_interrupt_request = '0;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        $onehot0(end_of_interrupt));

endmodule

//--- logic/pic_control_top.sv
// Interrupt controller command and acknowledge logic
// Single mode, 8086 vectors only, fed by an external request register
// and priority resolver

`timescale 1ns/1ps

module pic_control_top (
    input  logic                   clock,
    input  logic                   reset,
    input  pic_pkg::command_word_u data_bus,
    input  logic                   write_icw1,
    input  logic                   write_icw2_4,
    input  logic                   write_ocw1,
    input  logic                   write_ocw2,
    input  logic                   interrupt_acknowledge_n,
    input  pic_pkg::level_mask_t   interrupt,
    input  pic_pkg::level_mask_t   highest_level_in_service,
    output logic                   interrupt_to_cpu,
    output logic [7:0]             data_out,
    output logic                   data_out_enable,
    output logic                   level_triggered,
    output pic_pkg::level_mask_t   interrupt_mask,
    output pic_pkg::level_mask_t   end_of_interrupt,
    output pic_pkg::level_index_t  priority_rotate,
    output logic                   freeze,
    output logic                   latch_in_service,
    output pic_pkg::level_mask_t   clear_interrupt_request
);

    import pic_pkg::*;

    logic        load_icw2;
    logic        load_icw4;
    logic        load_ocw1;
    logic        load_ocw2;
    logic        icw4_enabled;
    logic        auto_eoi;
    logic [4:0]  vector_base;
    logic        end_of_ack_sequence;
    level_mask_t acknowledged_level;

    pic_command_sequencer i_pic_command_sequencer (
        .clock        (clock),
        .reset        (reset),
        .write_icw1   (write_icw1),
        .write_icw2_4 (write_icw2_4),
        .write_ocw1   (write_ocw1),
        .write_ocw2   (write_ocw2),
        .icw4_enabled (icw4_enabled),
        .load_icw2    (load_icw2),
        .load_icw4    (load_icw4),
        .load_ocw1    (load_ocw1),
        .load_ocw2    (load_ocw2)
    );

    pic_config_regs i_pic_config_regs (
        .clock           (clock),
        .reset           (reset),
        .data_bus        (data_bus),
        .write_icw1      (write_icw1),
        .load_icw2       (load_icw2),
        .load_icw4       (load_icw4),
        .load_ocw1       (load_ocw1),
        .vector_base     (vector_base),
        .level_triggered (level_triggered),
        .icw4_enabled    (icw4_enabled),
        .auto_eoi        (auto_eoi),
        .interrupt_mask  (interrupt_mask)
    );

    pic_ack_sequencer i_pic_ack_sequencer (
        .clock                   (clock),
        .reset                   (reset),
        .interrupt_acknowledge_n (interrupt_acknowledge_n),
        .load_ocw2               (load_ocw2),
        .interrupt               (interrupt),
        .vector_base             (vector_base),
        .acknowledged_level      (acknowledged_level),
        .latch_in_service        (latch_in_service),
        .end_of_ack_sequence     (end_of_ack_sequence),
        .interrupt_to_cpu        (interrupt_to_cpu),
        .freeze                  (freeze),
        .data_out_enable         (data_out_enable),
        .data_out                (data_out)
    );

    pic_priority_control i_pic_priority_control (
        .clock                    (clock),
        .reset                    (reset),
        .write_icw1               (write_icw1),
        .load_ocw2                (load_ocw2),
        .latch_in_service         (latch_in_service),
        .end_of_ack_sequence      (end_of_ack_sequence),
        .auto_eoi                 (auto_eoi),
        .data_bus                 (data_bus),
        .interrupt                (interrupt),
        .highest_level_in_service (highest_level_in_service),
        .acknowledged_level       (acknowledged_level),
        .end_of_interrupt         (end_of_interrupt),
        .clear_interrupt_request  (clear_interrupt_request),
        .priority_rotate          (priority_rotate)
    );

endmodule

//--- dv/pic_control_tb.sv
// Testbench for the interrupt controller command and acknowledge logic
// Writes command words, runs INTA sequences and checks the DUT with assertions

`timescale 1ns/1ps

module pic_control_tb;

    import pic_pkg::*;

    localparam int port_icw1 = 0;
    localparam int port_icw2_4 = 1;
    localparam int port_ocw1 = 2;
    localparam int port_ocw2 = 3;

    logic          clock;
    logic          reset;
    command_word_u data_bus;
    logic          write_icw1;
    logic          write_icw2_4;
    logic          write_ocw1;
    logic          write_ocw2;
    logic          interrupt_acknowledge_n;
    level_mask_t   interrupt;
    level_mask_t   highest_level_in_service;
    logic          interrupt_to_cpu;
    logic [7:0]    data_out;
    logic          data_out_enable;
    logic          level_triggered;
    level_mask_t   interrupt_mask;
    level_mask_t   end_of_interrupt;
    level_index_t  priority_rotate;
    logic          freeze;
    logic          latch_in_service;
    level_mask_t   clear_interrupt_request;

    // Expected state, built from the command words written so far
    logic          model_ready;
    logic          model_trigger;
    logic          model_aeoi;
    logic          model_auto_rotate;
    logic [4:0]    model_base;
    level_mask_t   expected_mask;
    level_mask_t   expected_eoi;
    level_mask_t   expected_aeoi;
    level_index_t  expected_rotate;
    level_index_t  request_level;
    logic          ack_idle;
    logic          first_pulse;
    logic          second_pulse;
    int            error_count;
    int            test_count;
    int            failed_tests;

    assign expected_aeoi = model_aeoi ? (8'h01 << request_level) : 8'h00;

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    pic_control_top i_pic_control_top (.*);

    task automatic report_mismatch(string signal_name, logic [7:0] expected, logic [7:0] actual);
        error_count++;
        $display("[FAIL] %0t %s expected %h got %h", $time, signal_name, expected, actual);
    endtask

    mask_after_reset: assert property (@(posedge clock) reset |=> interrupt_mask == 8'hff)
        else report_mismatch("interrupt_mask", 8'hff, $sampled(interrupt_mask));
    rotate_after_reset: assert property (@(posedge clock) reset |=> priority_rotate == 3'd7)
        else report_mismatch("priority_rotate", 8'h07, $sampled(priority_rotate));
    int_after_reset: assert property (@(posedge clock) reset |=> !interrupt_to_cpu)
        else report_mismatch("interrupt_to_cpu", 8'h00, $sampled(interrupt_to_cpu));
    freeze_after_reset: assert property (@(posedge clock) reset |=> freeze)
        else report_mismatch("freeze", 8'h01, $sampled(freeze));

    icw1_clears_requests: assert property (@(posedge clock) disable iff (reset)
        write_icw1 |-> clear_interrupt_request == 8'hff)
        else report_mismatch("clear_interrupt_request", 8'hff, $sampled(clear_interrupt_request));
    icw1_trigger: assert property (@(posedge clock) disable iff (reset)
        write_icw1 |=> level_triggered == model_trigger)
        else report_mismatch("level_triggered", model_trigger, $sampled(level_triggered));
    mask_load: assert property (@(posedge clock) disable iff (reset)
        write_ocw1 |=> interrupt_mask == expected_mask)
        else report_mismatch("interrupt_mask", expected_mask, $sampled(interrupt_mask));

    // INT path and the two acknowledge pulses
    int_rises: assert property (@(posedge clock) disable iff (reset)
        ack_idle && interrupt != 8'h00 && !write_ocw2 |=> interrupt_to_cpu)
        else report_mismatch("interrupt_to_cpu", 8'h01, $sampled(interrupt_to_cpu));
    latch_strobe: assert property (@(posedge clock) disable iff (reset)
        first_pulse && $fell(interrupt_acknowledge_n) |-> latch_in_service)
        else report_mismatch("latch_in_service", 8'h01, $sampled(latch_in_service));
    latch_clear: assert property (@(posedge clock) disable iff (reset)
        first_pulse && $fell(interrupt_acknowledge_n) |-> clear_interrupt_request == interrupt)
        else report_mismatch("clear_interrupt_request", $sampled(interrupt),
            $sampled(clear_interrupt_request));
    vector_enable: assert property (@(posedge clock) disable iff (reset)
        second_pulse && !interrupt_acknowledge_n |-> data_out_enable)
        else report_mismatch("data_out_enable", 8'h01, $sampled(data_out_enable));
    vector_freeze: assert property (@(posedge clock) disable iff (reset)
        second_pulse && !interrupt_acknowledge_n |-> freeze)
        else report_mismatch("freeze", 8'h01, $sampled(freeze));
    vector_value: assert property (@(posedge clock) disable iff (reset)
        second_pulse && !interrupt_acknowledge_n |-> data_out == {model_base, request_level})
        else report_mismatch("data_out", {model_base, request_level}, $sampled(data_out));
    int_falls: assert property (@(posedge clock) disable iff (reset)
        second_pulse && $rose(interrupt_acknowledge_n) |=> !interrupt_to_cpu)
        else report_mismatch("interrupt_to_cpu", 8'h00, $sampled(interrupt_to_cpu));
    auto_eoi_level: assert property (@(posedge clock) disable iff (reset)
        second_pulse && $rose(interrupt_acknowledge_n) |-> end_of_interrupt == expected_aeoi)
        else report_mismatch("end_of_interrupt", expected_aeoi, $sampled(end_of_interrupt));
    end_rotate: assert property (@(posedge clock) disable iff (reset)
        second_pulse && $rose(interrupt_acknowledge_n) |=> priority_rotate == expected_rotate)
        else report_mismatch("priority_rotate", expected_rotate, $sampled(priority_rotate));

    ocw2_eoi: assert property (@(posedge clock) disable iff (reset)
        write_ocw2 |-> end_of_interrupt == expected_eoi)
        else report_mismatch("end_of_interrupt", expected_eoi, $sampled(end_of_interrupt));
    ocw2_rotate: assert property (@(posedge clock) disable iff (reset)
        write_ocw2 |=> priority_rotate == expected_rotate)
        else report_mismatch("priority_rotate", expected_rotate, $sampled(priority_rotate));

    task automatic stall(string what);
        $display("timeout waiting for %s", what);
        $display("tests failed");
        $finish;
    endtask

    // Called on a falling edge, one strobe cycle then one idle cycle
    task automatic write_bus(int port, logic [7:0] value);
        data_bus.raw = value;
        write_icw1 = (port == port_icw1);
        write_icw2_4 = (port == port_icw2_4);
        write_ocw1 = (port == port_ocw1);
        write_ocw2 = (port == port_ocw2);
        @(negedge clock);
        write_icw1 = 1'b0;
        write_icw2_4 = 1'b0;
        write_ocw1 = 1'b0;
        write_ocw2 = 1'b0;
        data_bus.raw = 8'h00;
        @(negedge clock);
    endtask

    // Single mode, 8086 mode when ICW4 follows
    task automatic initialize(logic trigger, logic use_icw4, logic aeoi, logic [4:0] base);
        model_ready = 1'b0;
        model_trigger = trigger;
        write_bus(port_icw1, {3'b000, 1'b1, trigger, 1'b0, 1'b1, use_icw4});
        model_base = base;
        model_ready = !use_icw4;
        write_bus(port_icw2_4, {base, 3'($urandom)});
        if (use_icw4) begin
            model_aeoi = aeoi;
            model_ready = 1'b1;
            write_bus(port_icw2_4, {6'b000000, aeoi, 1'b1});
        end
    endtask

    task automatic write_mask(level_mask_t value);
        if (model_ready) begin
            expected_mask = value;
        end
        write_bus(port_ocw1, value);
    endtask

    task automatic send_operation(ocw2_op_t op, level_index_t level);
        level_index_t in_service_index;
        in_service_index = 3'($urandom);
        highest_level_in_service = 8'h01 << in_service_index;
        expected_eoi = 8'h00;
        if (model_ready) begin
            case (op)
                eoi_nonspecific, rotate_nonspecific: expected_eoi = highest_level_in_service;
                eoi_specific, rotate_specific:       expected_eoi = 8'h01 << level;
                default:                             expected_eoi = 8'h00;
            endcase
            case (op)
                rotate_nonspecific:            expected_rotate = in_service_index;
                set_priority, rotate_specific: expected_rotate = level;
                rotate_auto_set:               model_auto_rotate = 1'b1;
                rotate_auto_clear:             model_auto_rotate = 1'b0;
                default:                       expected_rotate = expected_rotate;
            endcase
        end
        write_bus(port_ocw2, {op, 2'b00, level});
    endtask

    task automatic run_acknowledge(level_index_t level);
        int wait_cycles;
        request_level = level;
        interrupt = 8'h01 << level;
        wait_cycles = 0;
        while (!interrupt_to_cpu) begin
            if (wait_cycles == 20) begin
                stall("interrupt_to_cpu to rise");
            end
            @(negedge clock);
            wait_cycles++;
        end
        ack_idle = 1'b0;
        first_pulse = 1'b1;
        interrupt_acknowledge_n = 1'b0;
        @(negedge clock);
        // Request register drops the level once it is latched
        first_pulse = 1'b0;
        interrupt = 8'h00;
        @(negedge clock);
        interrupt_acknowledge_n = 1'b1;
        @(negedge clock);
        second_pulse = 1'b1;
        interrupt_acknowledge_n = 1'b0;
        repeat (2) @(negedge clock);
        interrupt_acknowledge_n = 1'b1;
        if (model_auto_rotate) begin
            expected_rotate = level;
        end
        @(negedge clock);
        second_pulse = 1'b0;
        wait_cycles = 0;
        while (interrupt_to_cpu) begin
            if (wait_cycles == 20) begin
                stall("interrupt_to_cpu to fall");
            end
            @(negedge clock);
            wait_cycles++;
        end
        ack_idle = 1'b1;
        @(negedge clock);
    endtask

    task automatic finish_test(string name, int errors_before);
        repeat (2) @(negedge clock);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
        end
    endtask

    initial begin
        int errors_before;
        void'($urandom(32'h849f5a1e));
        reset = 1'b1;
        data_bus.raw = 8'h00;
        write_icw1 = 1'b0;
        write_icw2_4 = 1'b0;
        write_ocw1 = 1'b0;
        write_ocw2 = 1'b0;
        interrupt_acknowledge_n = 1'b1;
        interrupt = 8'h00;
        highest_level_in_service = 8'h00;
        model_ready = 1'b0;
        model_trigger = 1'b0;
        model_aeoi = 1'b0;
        model_auto_rotate = 1'b0;
        model_base = 5'd0;
        expected_mask = 8'hff;
        expected_eoi = 8'h00;
        expected_rotate = 3'd7;
        request_level = 3'd0;
        ack_idle = 1'b1;
        first_pulse = 1'b0;
        second_pulse = 1'b0;
        error_count = 0;
        test_count = 0;
        failed_tests = 0;
        repeat (3) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);

        errors_before = error_count;
        model_trigger = 1'b0;
        write_bus(port_icw1, 8'b0001_0010);
        // ICW2 still expected here
        write_mask(8'($urandom));
        model_base = 5'($urandom);
        model_ready = 1'b1;
        write_bus(port_icw2_4, {model_base, 3'b000});
        write_mask(8'($urandom));
        finish_test("reset and masking", errors_before);

        errors_before = error_count;
        initialize(1'b1, 1'b0, 1'b0, 5'($urandom));
        initialize(1'b0, 1'b0, 1'b0, 5'($urandom));
        finish_test("icw1 effects", errors_before);

        errors_before = error_count;
        repeat (4) begin
            run_acknowledge(3'($urandom));
        end
        finish_test("acknowledge sequence", errors_before);

        errors_before = error_count;
        initialize(1'b0, 1'b1, 1'b1, 5'($urandom));
        run_acknowledge(3'($urandom));
        initialize(1'b0, 1'b1, 1'b0, 5'($urandom));
        run_acknowledge(3'($urandom));
        finish_test("automatic eoi", errors_before);

        errors_before = error_count;
        repeat (3) begin
            send_operation(eoi_nonspecific, 3'($urandom));
            send_operation(eoi_specific, 3'($urandom));
        end
        finish_test("ocw2 eoi commands", errors_before);

        errors_before = error_count;
        send_operation(set_priority, 3'($urandom));
        send_operation(rotate_nonspecific, 3'($urandom));
        send_operation(rotate_auto_set, 3'd0);
        run_acknowledge(3'($urandom));
        run_acknowledge(3'($urandom));
        send_operation(rotate_auto_clear, 3'd0);
        run_acknowledge(3'($urandom));
        finish_test("ocw2 rotation", errors_before);

        $display("summary: %0d tests, %0d with errors, %0d check errors",
            test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
logic/pic_pkg.sv
logic/pic_command_sequencer.sv
logic/pic_config_regs.sv
logic/pic_ack_sequencer.sv
logic/pic_priority_control.sv
logic/pic_control_top.sv
dv/pic_control_tb.sv

//--- Bender.yml
package:
  name: pic_control

sources:
  - logic/pic_pkg.sv
  - logic/pic_command_sequencer.sv
  - logic/pic_config_regs.sv
  - logic/pic_ack_sequencer.sv
  - logic/pic_priority_control.sv
  - logic/pic_control_top.sv
  - target: test
    files:
      - dv/pic_control_tb.sv
